//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_vic_sprites
FLIST     = flist.f
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

//--- flist.f
rtl/vic_pkg.sv
rtl/sprite_cfg_if.sv
rtl/sprite_regs.sv
rtl/sprite_unit.sv
rtl/sprite_mixer.sv
rtl/vic_sprite_top.sv
verification/vic_sprites_sva.sv
verification/tb_vic_sprites.sv

//--- rtl/sprite_cfg_if.sv
`timescale 1ns/1ns
`default_nettype none

// per-sprite configuration, static levels held until the cpu rewrites them
interface sprite_cfg_if import vic_pkg::*; ();

  logic [X_W-1:0]       x;        // left edge, bit 8 from the msb register
  logic [Y_W-1:0]       y;        // top line
  logic                 enable;
  logic [COLOR_W-1:0]   color;
  logic [SPR_WIDTH-1:0] pattern;  // msb is the leftmost pixel

  // register file side
  modport src (
    output x,
    output y,
    output enable,
    output color,
    output pattern
  );

  // sprite unit side
  modport dst (
    input x,
    input y,
    input enable,
    input color,
    input pattern
  );

endinterface : sprite_cfg_if

`default_nettype wire

//--- rtl/sprite_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_mixer import vic_pkg::*; (
  input  wire logic                   clk_col4x_pal,
  input  wire logic                   rst,
  input  wire logic [NUM_SPRITES-1:0] pix_on,
  input  wire logic [COLOR_W-1:0]     pix_color [NUM_SPRITES],
  output logic                        sprite_active,
  output logic [COLOR_W-1:0]          sprite_color,
  output logic [NUM_SPRITES-1:0]      coll_mask
);

  logic [COLOR_W-1:0] win_color;
  logic               multi_hit;

  // walk from the top down so the lowest sprite overwrites last and wins
  always_comb begin
    win_color = '0;
    for (int n = NUM_SPRITES - 1; n >= 0; n--) begin
      if (pix_on[n]) win_color = pix_color[n];
    end
  end

  // clearing the lowest set bit leaves something only when two or more are on
  assign multi_hit = |(pix_on & (pix_on - 1'b1));

  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      sprite_active <= 1'b0;
      sprite_color  <= '0;
      coll_mask     <= '0;
    end else begin
      sprite_active <= |pix_on;
      sprite_color  <= win_color;
      coll_mask     <= multi_hit ? pix_on : '0;  // every sprite in the overlap
    end
  end

endmodule : sprite_mixer

`default_nettype wire

//--- rtl/sprite_regs.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_regs import vic_pkg::*; (
  input  wire logic              clk_col4x_pal,
  input  wire logic              rst,
  input  wire logic              ce,          // active low chip enable
  input  wire logic              rw,          // high = read
  input  wire logic [ADDR_W-1:0] adl,
  input  wire logic [7:0]        dbi,
  input  wire logic [NUM_SPRITES-1:0] coll_mask,  // from the mixer
  output logic [7:0]             dbo,
  output logic                   vic_write_db,
  output logic                   irq,
  sprite_cfg_if.src              cfg [NUM_SPRITES]
);

  bus_op_e bus_op;
  int      addr;                              // adl widened for map compares

  logic [7:0]             x_lo      [NUM_SPRITES];
  logic [Y_W-1:0]         y_pos     [NUM_SPRITES];
  logic [NUM_SPRITES-1:0] x_msb;
  logic [NUM_SPRITES-1:0] spr_en;
  logic [COLOR_W-1:0]     spr_color [NUM_SPRITES];
  logic [7:0]             pat_byte  [NUM_SPRITES][PAT_BYTES];
  logic [SPR_WIDTH-1:0]   pat_word  [NUM_SPRITES];
  logic [NUM_SPRITES-1:0] coll_latch;
  logic [7:0]             rd_data;
  logic                   coll_rd;

  // ce is active low, rw picks direction
  always_comb begin
    if (ce) begin
      bus_op = BUS_IDLE;
    end else if (rw) begin
      bus_op = BUS_READ;
    end else begin
      bus_op = BUS_WRITE;
    end
  end

  assign addr = int'(adl);

  // cpu writes
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      x_msb  <= '0;
      spr_en <= '0;                           // all sprites off
      for (int n = 0; n < NUM_SPRITES; n++) begin
        x_lo[n]      <= '0;
        y_pos[n]     <= '0;
        spr_color[n] <= '0;
        for (int b = 0; b < PAT_BYTES; b++) begin
          pat_byte[n][b] <= '0;
        end
      end
    end else if (bus_op == BUS_WRITE) begin
      if (addr == REG_X_MSB)  x_msb  <= dbi;
      if (addr == REG_ENABLE) spr_en <= dbi;
      for (int n = 0; n < NUM_SPRITES; n++) begin
        if (addr == 2 * n)              x_lo[n]      <= dbi;
        if (addr == 2 * n + 1)          y_pos[n]     <= dbi;
        if (addr == REG_COLOR_BASE + n) spr_color[n] <= dbi[COLOR_W-1:0];  // high nibble dropped
        for (int b = 0; b < PAT_BYTES; b++) begin
          if (addr == REG_PAT_BASE + PAT_BYTES * n + b) pat_byte[n][b] <= dbi;
        end
      end
    end
  end

  // read-back mux, anything not decoded floats high like the real chip
  always_comb begin
    rd_data = 8'hff;
    if (addr == REG_X_MSB)   rd_data = x_msb;
    if (addr == REG_ENABLE)  rd_data = spr_en;
    if (addr == REG_SS_COLL) rd_data = coll_latch;  // value before the clear
    for (int n = 0; n < NUM_SPRITES; n++) begin
      if (addr == 2 * n)     rd_data = x_lo[n];
      if (addr == 2 * n + 1) rd_data = y_pos[n];
      if (addr == REG_COLOR_BASE + n) begin
        rd_data = {{(8 - COLOR_W){1'b1}}, spr_color[n]};  // unused bits read 1
      end
      for (int b = 0; b < PAT_BYTES; b++) begin
        if (addr == REG_PAT_BASE + PAT_BYTES * n + b) rd_data = pat_byte[n][b];
      end
    end
  end

  assign coll_rd = (bus_op == BUS_READ) && (addr == REG_SS_COLL);

  // read data, bus enable and the collision latch
  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      dbo          <= '0;
      vic_write_db <= 1'b0;
      coll_latch   <= '0;
    end else begin
      vic_write_db <= (bus_op == BUS_READ);   // one cycle per read strobe
      if (bus_op == BUS_READ) dbo <= rd_data; // hold last value otherwise
      // new hits in the read cycle survive the clear
      coll_latch <= (coll_rd ? '0 : coll_latch) | coll_mask;
    end
  end

  assign irq = |coll_latch;                   // follows the latch directly

  // pack pattern bytes, byte 0 into the top bits
  always_comb begin
    for (int n = 0; n < NUM_SPRITES; n++) begin
      for (int b = 0; b < PAT_BYTES; b++) begin
        pat_word[n][SPR_WIDTH-1-8*b -: 8] = pat_byte[n][b];
      end
    end
  end

  for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_cfg
    assign cfg[g].x       = {x_msb[g], x_lo[g]};
    assign cfg[g].y       = y_pos[g];
    assign cfg[g].enable  = spr_en[g];
    assign cfg[g].color   = spr_color[g];
    assign cfg[g].pattern = pat_word[g];
  end

endmodule : sprite_regs

`default_nettype wire

//--- rtl/sprite_unit.sv
`timescale 1ns/1ns
`default_nettype none

module sprite_unit import vic_pkg::*; (
  input  wire logic           clk_col4x_pal,
  input  wire logic           rst,
  input  wire logic [X_W-1:0] raster_x,
  input  wire logic [Y_W-1:0] raster_y,
  sprite_cfg_if.dst           cfg,
  output logic                pix_on,
  output logic [COLOR_W-1:0]  pix_color
);

  logic [X_W:0]         x_off;                // one extra bit so left of x wraps large
  logic [Y_W:0]         y_off;
  logic                 in_x;
  logic                 in_y;
  logic [SPR_WIDTH-1:0] pat_shift;
  logic                 hit;

  // offsets into the sprite box
  assign x_off = {1'b0, raster_x} - {1'b0, cfg.x};
  assign y_off = {1'b0, raster_y} - {1'b0, cfg.y};

  assign in_x = (x_off < SPR_WIDTH);          // x .. x+23
  assign in_y = (y_off < SPR_HEIGHT);         // y .. y+20

  // column 0 is the pattern msb, shift it up to the top
  assign pat_shift = cfg.pattern << x_off;

  assign hit = cfg.enable && in_x && in_y && pat_shift[SPR_WIDTH-1];

  always_ff @(posedge clk_col4x_pal) begin
    if (rst) begin
      pix_on    <= 1'b0;
      pix_color <= '0;
    end else begin
      pix_on    <= hit;
      pix_color <= hit ? cfg.color : '0;      // transparent pixels carry 0
    end
  end

endmodule : sprite_unit

`default_nettype wire

//--- rtl/vic_pkg.sv
`default_nettype none

package vic_pkg;

  // sprite geometry
  localparam int NUM_SPRITES = 8;
  localparam int SPR_WIDTH   = 24;          // pixels per pattern row
  localparam int SPR_HEIGHT  = 21;          // raster lines per sprite
  localparam int PAT_BYTES   = SPR_WIDTH / 8; // pattern bytes per sprite

  // pixel and position widths
  localparam int COLOR_W = 4;
  localparam int X_W     = 9;               // raster x and sprite x
  localparam int Y_W     = 8;               // raster y and sprite y
  localparam int ADDR_W  = 6;               // register port address lines

  // register map
  // 0x00..0x0f hold x low at 2n and y at 2n+1 for sprite n
  localparam int REG_X_MSB      = 'h10;     // bit n is x bit 8 of sprite n
  localparam int REG_ENABLE     = 'h15;     // one enable bit per sprite
  localparam int REG_SS_COLL    = 'h1e;     // sprite to sprite collisions, clear on read
  localparam int REG_COLOR_BASE = 'h27;     // 0x27..0x2e, low nibble used
  // three bytes per sprite, byte 0 leftmost
  // the 6-bit port reaches 0x3f, so bytes above that keep their reset value
  localparam int REG_PAT_BASE   = 'h30;

  // bus operation decoded from ce and rw
  typedef enum logic [1:0] {
    BUS_IDLE  = 2'd0,     // ce high
    BUS_WRITE = 2'd1,     // ce low, rw low
    BUS_READ  = 2'd2      // ce low, rw high
  } bus_op_e;

endpackage : vic_pkg

`default_nettype wire

//--- rtl/vic_sprite_top.sv
`timescale 1ns/1ns
`default_nettype none

module vic_sprite_top import vic_pkg::*; (
  input  wire logic              clk_col4x_pal,
  input  wire logic              rst,
  input  wire logic              ce,            // low = chip selected
  input  wire logic              rw,            // low = write
  input  wire logic [ADDR_W-1:0] adl,
  input  wire logic [7:0]        dbi,
  output logic [7:0]             dbo,
  output logic                   vic_write_db,  // board drives the data pins when high
  output logic                   sprite_active,
  output logic [COLOR_W-1:0]     sprite_color,
  output logic                   irq,
  input  wire logic [X_W-1:0]    raster_x,
  input  wire logic [Y_W-1:0]    raster_y
);

  logic [NUM_SPRITES-1:0] pix_on;
  logic [COLOR_W-1:0]     pix_color [NUM_SPRITES];
  logic [NUM_SPRITES-1:0] coll_mask;

  sprite_cfg_if cfg_if [NUM_SPRITES] ();      // one config bundle per sprite

  // cpu register port, also holds the collision latch
  sprite_regs u_regs (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .ce            (ce),
    .rw            (rw),
    .adl           (adl),
    .dbi           (dbi),
    .coll_mask     (coll_mask),
    .dbo           (dbo),
    .vic_write_db  (vic_write_db),
    .irq           (irq),
    .cfg           (cfg_if)
  );

  // first pipeline stage, each unit tests its own box
  for (genvar g = 0; g < NUM_SPRITES; g++) begin : g_sprite
    sprite_unit u_unit (
      .clk_col4x_pal (clk_col4x_pal),
      .rst           (rst),
      .raster_x      (raster_x),
      .raster_y      (raster_y),
      .cfg           (cfg_if[g]),
      .pix_on        (pix_on[g]),
      .pix_color     (pix_color[g])
    );
  end

  // second stage, priority and collisions
  sprite_mixer u_mixer (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .pix_on        (pix_on),
    .pix_color     (pix_color),
    .sprite_active (sprite_active),
    .sprite_color  (sprite_color),
    .coll_mask     (coll_mask)
  );

endmodule : vic_sprite_top

`default_nettype wire

//--- verification/sprite_patterns.hex
// op adl data raster_x raster_y expect, all hex
// op 1 write, 2 read check, 3 pixel check (expect = active<<4 | colour), 4 irq check, 0 end
1 00 64 000 00 00
1 01 32 000 00 00
1 27 a7 000 00 00
1 30 a5 000 00 00
1 32 81 000 00 00
1 15 27 000 00 00
2 00 00 000 00 64
2 27 00 000 00 f7
2 30 00 000 00 a5
2 15 00 000 00 27
2 20 00 000 00 ff
3 00 00 064 32 17
3 00 00 07b 32 17
3 00 00 064 46 17
3 00 00 07b 46 17
3 00 00 063 32 00
3 00 00 07b 47 00
3 00 00 065 3c 00
1 02 2c 000 00 00
1 03 64 000 00 00
1 10 02 000 00 00
1 33 ff 000 00 00
1 28 02 000 00 00
3 00 00 12c 64 12
3 00 00 02c 64 00
1 04 c8 000 00 00
1 0a cc 000 00 00
1 36 ff 000 00 00
1 3f ff 000 00 00
1 29 0a 000 00 00
1 2c 0e 000 00 00
3 00 00 0cd 05 1a
4 00 00 000 00 01
2 1e 00 000 00 24
4 00 00 000 00 00
2 1e 00 000 00 00
1 15 23 000 00 00
3 00 00 0cd 05 1e
0 00 00 000 00 00

//--- verification/tb_vic_sprites.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vic_sprites import vic_pkg::*; ();

  logic               clk_col4x_pal;
  logic               rst;
  logic               ce;
  logic               rw;
  logic [ADDR_W-1:0]  adl;
  logic [7:0]         dbi;
  logic [7:0]         dbo;
  logic               vic_write_db;
  logic               sprite_active;
  logic [COLOR_W-1:0] sprite_color;
  logic               irq;
  logic [X_W-1:0]     raster_x;
  logic [Y_W-1:0]     raster_y;

  logic [15:0] rec_mem [0:6*64-1];   // six words per record, up to 64 records

  vic_sprite_top DUT (
    .clk_col4x_pal (clk_col4x_pal),
    .rst           (rst),
    .ce            (ce),
    .rw            (rw),
    .adl           (adl),
    .dbi           (dbi),
    .dbo           (dbo),
    .vic_write_db  (vic_write_db),
    .sprite_active (sprite_active),
    .sprite_color  (sprite_color),
    .irq           (irq),
    .raster_x      (raster_x),
    .raster_y      (raster_y)
  );

  always #10 clk_col4x_pal = ~clk_col4x_pal;   // 20 ns period

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk_col4x_pal);
    @(negedge clk_col4x_pal);
    rst = 1'b0;
  end

  task automatic check_value(input string name, input logic [15:0] actual,
                             input logic [15:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s = 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      $display("Test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "run aborted");
  endtask

  // far corner, outside every box in the pattern file
  task automatic park_raster();
    raster_x = '1;
    raster_y = '1;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst !== 1'b0 && cycles < 10) begin
      @(posedge clk_col4x_pal);
      cycles++;
    end
    if (rst !== 1'b0) fail_run("reset was still asserted after 10 cycles");
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
    ce  = 1'b0;
    rw  = 1'b0;
    adl = addr;
    dbi = data;
    @(negedge clk_col4x_pal);          // strobe seen by one rising edge
    ce = 1'b1;
    rw = 1'b1;
  endtask

  task automatic bus_read_check(input logic [ADDR_W-1:0] addr, input logic [7:0] expected);
    ce  = 1'b0;
    rw  = 1'b1;
    adl = addr;
    @(negedge clk_col4x_pal);
    ce = 1'b1;                         // data now registered
    check_value("vic_write_db", 16'(vic_write_db), 16'h0001);
    check_value("dbo", 16'(dbo), 16'(expected));
  endtask

  // unit stage then mixer stage, result two falling edges after the raster
  task automatic pixel_check(input logic [X_W-1:0] rx, input logic [Y_W-1:0] ry,
                             input logic [7:0] expected);
    raster_x = rx;
    raster_y = ry;
    @(negedge clk_col4x_pal);
    park_raster();
    @(negedge clk_col4x_pal);
    check_value("sprite_active", 16'(sprite_active), 16'(expected[4]));
    check_value("sprite_color", 16'(sprite_color), 16'(expected[3:0]));
  endtask

  task automatic irq_check(input logic expected);
    @(negedge clk_col4x_pal);          // lets the latch take the last mask
    check_value("irq", 16'(irq), 16'(expected));
  endtask

  initial begin
    int base;
    bit done;
    bit bad_op;
    clk_col4x_pal = 1'b0;
    ce  = 1'b1;                        // bus idle
    rw  = 1'b1;
    adl = '0;
    dbi = '0;
    park_raster();
    done   = 1'b0;
    bad_op = 1'b0;
    $readmemh("verification/sprite_patterns.hex", rec_mem);
    wait_reset_release();
    @(negedge clk_col4x_pal);
    check_value("dbo", 16'(dbo), 16'h0000);
    check_value("vic_write_db", 16'(vic_write_db), 16'h0000);
    check_value("sprite_active", 16'(sprite_active), 16'h0000);
    check_value("sprite_color", 16'(sprite_color), 16'h0000);
    check_value("irq", 16'(irq), 16'h0000);
    for (int r = 0; r < 64 && !done; r++) begin
      base = 6 * r;
      case (rec_mem[base])
        16'h0: done = 1'b1;
        16'h1: bus_write(rec_mem[base+1][ADDR_W-1:0], rec_mem[base+2][7:0]);
        16'h2: bus_read_check(rec_mem[base+1][ADDR_W-1:0], rec_mem[base+5][7:0]);
        16'h3: pixel_check(rec_mem[base+3][X_W-1:0], rec_mem[base+4][Y_W-1:0],
                           rec_mem[base+5][7:0]);
        16'h4: irq_check(rec_mem[base+5][0]);
        default: begin
          bad_op = 1'b1;
          done   = 1'b1;
        end
      endcase
    end
    if (bad_op) begin
      fail_run("unknown op code in the pattern file");
    end else if (!done) begin
      fail_run("pattern file has no end record");
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule : tb_vic_sprites

`default_nettype wire

//--- verification/vic_sprites_sva.sv
`timescale 1ns/1ns
`default_nettype none

module vic_sprites_sva import vic_pkg::*; (
  input wire logic                   clk_col4x_pal,
  input wire logic                   rst,
  input wire logic                   ce,
  input wire logic                   rw,
  input wire logic [ADDR_W-1:0]      adl,
  input wire logic [7:0]             dbo,
  input wire logic                   vic_write_db,
  input wire logic                   sprite_active,
  input wire logic [COLOR_W-1:0]     sprite_color,
  input wire logic                   irq,
  input wire logic [NUM_SPRITES-1:0] coll_latch    // taken from the register file
);

  bus_op_e op;
  logic    coll_read;

  assign op = ce ? BUS_IDLE : (rw ? BUS_READ : BUS_WRITE);

  assign coll_read = (op == BUS_READ) && (adl == REG_SS_COLL);  // clear strobe

  // bus enable is high exactly in the cycle after a read strobe
  a_write_db: assert property (@(posedge clk_col4x_pal) disable iff (rst)
    vic_write_db == $past(op == BUS_READ))
    else $error("vic_write_db does not follow the read strobe");

  a_color_idle: assert property (@(posedge clk_col4x_pal) disable iff (rst)
    !sprite_active |-> sprite_color == '0)              // no colour without a sprite
    else $error("sprite_color nonzero while sprite_active is low");

  // latched hits and irq stay up until the cpu reads the collision register
  a_irq: assert property (@(posedge clk_col4x_pal) disable iff (rst)
    irq && !coll_read |=> irq && (coll_latch & $past(coll_latch)) == $past(coll_latch))
    else $error("collision latch or irq dropped without a read of the collision register");

  // everything back at zero one edge into reset
  a_reset: assert property (@(posedge clk_col4x_pal)
    $past(rst) |-> !vic_write_db && !sprite_active && !irq && dbo == 8'h00
                   && sprite_color == '0)
    else $error("outputs not at reset values during reset");

endmodule : vic_sprites_sva

bind vic_sprite_top vic_sprites_sva u_sva (
  .clk_col4x_pal (clk_col4x_pal),
  .rst           (rst),
  .ce            (ce),
  .rw            (rw),
  .adl           (adl),
  .dbo           (dbo),
  .vic_write_db  (vic_write_db),
  .sprite_active (sprite_active),
  .sprite_color  (sprite_color),
  .irq           (irq),
  .coll_latch    (u_regs.coll_latch)
);

`default_nettype wire
